// File: include/afe_params.svh
// fast analog front end, board widths and codes
// shared by the adc decode and dac output stages

`ifndef AFE_PARAMS_SVH
`define AFE_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// adc side
//////////////////////////////////////////////////////////////////////

// raw adc pin word
`define AFE_ADC_W 16

// reserved low bits of the 16 bit adc word
`define AFE_ADC_PAD 2

//////////////////////////////////////////////////////////////////////
// data path
//////////////////////////////////////////////////////////////////////

`define AFE_SMP_W 14 // signed sample, both directions

`define AFE_SUM_W 15 // generator + controller, one guard bit

// unsigned neg-slope code of signed zero
// top bit kept, lower 13 inverted
`define AFE_DAC_IDLE 14'h1FFF

`endif

// File: src/afe_pkg.sv
// fast analog data path types
// samples, channel pairs, limiter and static config records

`default_nettype none

package afe_pkg;

  `include "afe_params.svh"

  typedef logic signed [`AFE_SMP_W-1:0] sample_t; // two's complement
  typedef logic signed [`AFE_SUM_W-1:0] sum_t;    // asg + pid, pre saturation

  typedef logic [1:0] rail_t; // [1] upper hit, [0] lower hit

  typedef struct packed {
    sample_t ch_a;
    sample_t ch_b;
  } smp_pair_t;

  // raw adc pins, unsigned negative slope
  typedef struct packed {
    logic [`AFE_ADC_W-1:0] ch_a;
    logic [`AFE_ADC_W-1:0] ch_b;
  } raw_pair_t;

  typedef struct packed {
    rail_t ch_a;
    rail_t ch_b;
  } rail_pair_t;

  typedef struct packed {
    sample_t lim_max;
    sample_t lim_min;
  } lim_cfg_t;

  typedef struct packed {
    logic     digital_loop; // feed limited dac values back as adc
    lim_cfg_t lim_a;
    lim_cfg_t lim_b;
  } afe_cfg_t;

  // words as they go to the dac chip
  typedef struct packed {
    logic [`AFE_SMP_W-1:0] ch_a;
    logic [`AFE_SMP_W-1:0] ch_b;
  } dac_pair_t;

endpackage

`default_nettype wire

// File: src/adc_decode.sv
// adc decode stage
// captures both adc words, drops the pad bits and converts the
// unsigned negative-slope code to two's complement, with loopback

`timescale 1ns/100ps
`default_nettype none

`include "afe_params.svh"

module adc_decode
  import afe_pkg::*;
(
  input  wire       adc_clk,
  input  wire       rst_n_i,    // sync, active low
  input  raw_pair_t raw_i,      // adc pins
  input  wire       loop_i,     // digital loop on
  input  smp_pair_t loop_dat_i, // limited dac values
  output smp_pair_t smp_o
);

  //////////////////////////////////////////////////////////////////////
  // capture
  //////////////////////////////////////////////////////////////////////

  logic [`AFE_SMP_W-1:0] trim_a; // pad bits dropped
  logic [`AFE_SMP_W-1:0] trim_b;
  smp_pair_t             adc_q;  // stands in for the io block register

  assign trim_a = raw_i.ch_a[`AFE_ADC_W-1:`AFE_ADC_PAD];
  assign trim_b = raw_i.ch_b[`AFE_ADC_W-1:`AFE_ADC_PAD];

  // neg slope -> two's complement, msb kept, rest inverted
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      adc_q <= '0;
    end
    else
    begin
      adc_q.ch_a <= {trim_a[`AFE_SMP_W-1], ~trim_a[`AFE_SMP_W-2:0]};
      adc_q.ch_b <= {trim_b[`AFE_SMP_W-1], ~trim_b[`AFE_SMP_W-2:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // loop select
  //////////////////////////////////////////////////////////////////////

  // same cycle as lim_dat, no extra register
  assign smp_o = loop_i ? loop_dat_i : adc_q;

endmodule

`default_nettype wire

// File: src/dac_limit.sv
// dac limit stage
// adds generator and controller samples, saturates to 14 bits, clamps
// to the per channel limits, flags railing and reports range center

`timescale 1ns/100ps
`default_nettype none

`include "afe_params.svh"

module dac_limit
  import afe_pkg::*;
(
  input  wire        adc_clk,
  input  wire        rst_n_i,  // sync, active low
  input  smp_pair_t  asg_i,    // generator
  input  smp_pair_t  pid_i,    // controller
  input  lim_cfg_t   lim_a_i,
  input  lim_cfg_t   lim_b_i,
  output smp_pair_t  dat_o,    // limited, to dac and loop
  output rail_pair_t railed_o,
  output smp_pair_t  center_o  // for integrator reset
);

  //////////////////////////////////////////////////////////////////////
  // per channel helpers
  //////////////////////////////////////////////////////////////////////

  // top two bits differ -> out of 14 bit range
  function automatic sample_t sat_f(input sum_t s);
    if (s[`AFE_SUM_W-1] ^ s[`AFE_SUM_W-2])
      return {s[`AFE_SUM_W-1], {(`AFE_SMP_W-1){~s[`AFE_SUM_W-1]}}};
    return s[`AFE_SMP_W-1:0];
  endfunction

  // upper check first, wins when limits cross
  function automatic sample_t clamp_f(input sample_t v, input lim_cfg_t l);
    if (v > l.lim_max) return l.lim_max;
    if (v < l.lim_min) return l.lim_min;
    return v;
  endfunction

  function automatic rail_t rail_f(input sample_t v, input lim_cfg_t l);
    if (v > l.lim_max) return 2'b10;
    if (v < l.lim_min) return 2'b01;
    return 2'b00;
  endfunction

  // floor((max+min)/2) from halves, no overflow
  function automatic sample_t mid_f(input lim_cfg_t l);
    return (l.lim_max >>> 1) + (l.lim_min >>> 1)
         + sample_t'(l.lim_max[0] & l.lim_min[0]);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////

  sum_t    sum_a, sum_b; // one guard bit
  sample_t sat_a, sat_b;

  assign sum_a = sum_t'(asg_i.ch_a) + sum_t'(pid_i.ch_a);
  assign sum_b = sum_t'(asg_i.ch_b) + sum_t'(pid_i.ch_b);
  assign sat_a = sat_f(sum_a);
  assign sat_b = sat_f(sum_b);

  //////////////////////////////////////////////////////////////////////
  // limit registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dat_o    <= '0;
      railed_o <= '0;
    end
    else
    begin
      dat_o.ch_a    <= clamp_f(sat_a, lim_a_i);
      dat_o.ch_b    <= clamp_f(sat_b, lim_b_i);
      railed_o.ch_a <= rail_f(sat_a, lim_a_i);
      railed_o.ch_b <= rail_f(sat_b, lim_b_i);
    end
  end

  // center follows the static limits
  always_ff @(posedge adc_clk)
  begin
    center_o.ch_a <= mid_f(lim_a_i);
    center_o.ch_b <= mid_f(lim_b_i);
  end

endmodule

`default_nettype wire

// File: src/dac_encode.sv
// dac output stage
// registers both channels as unsigned negative-slope dac code and
// produces the registered active high dac chip reset

`timescale 1ns/100ps
`default_nettype none

`include "afe_params.svh"

module dac_encode
  import afe_pkg::*;
(
  input  wire       adc_clk,
  input  wire       rst_n_i,  // sync, active low
  input  smp_pair_t dat_i,    // limited samples
  output dac_pair_t dac_o,    // to dac pins
  output logic      dac_rst_o // dac chip reset, active high
);

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  // signed -> unsigned neg slope, same bit flip as the adc side
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_o.ch_a <= `AFE_DAC_IDLE; // mid scale while in reset
      dac_o.ch_b <= `AFE_DAC_IDLE;
    end
    else
    begin
      dac_o.ch_a <= {dat_i.ch_a[`AFE_SMP_W-1], ~dat_i.ch_a[`AFE_SMP_W-2:0]};
      dac_o.ch_b <= {dat_i.ch_b[`AFE_SMP_W-1], ~dat_i.ch_b[`AFE_SMP_W-2:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // dac reset
  //////////////////////////////////////////////////////////////////////

  // high while rst_n_i low, drops on first edge after release
  always_ff @(posedge adc_clk)
  begin
    dac_rst_o <= ~rst_n_i;
  end

endmodule

`default_nettype wire

// File: src/afe_datapath_top.sv
// two channel fast analog data path
// adc decode with digital loop, dac sum/limit and dac output encode

`timescale 1ns/100ps
`default_nettype none

module afe_datapath_top
  import afe_pkg::*;
(
  input  wire        adc_clk,
  input  wire        rst_n_i,   // sync, active low
  // adc pins
  input  raw_pair_t  adc_raw_i,
  // external streams
  input  smp_pair_t  asg_i,     // generator
  input  smp_pair_t  pid_i,     // controller
  // static configuration
  input  afe_cfg_t   cfg_i,
  // results
  output smp_pair_t  adc_smp_o, // decoded or looped adc samples
  output smp_pair_t  center_o,  // limit range centers
  output rail_pair_t railed_o,  // limiter status
  output dac_pair_t  dac_dat_o, // dac words
  output logic       dac_rst_o  // dac chip reset
);

  smp_pair_t lim_dat; // limited dac values, also the loop source

  //////////////////////////////////////////////////////////////////////
  // adc side
  //////////////////////////////////////////////////////////////////////

  adc_decode u_adc_decode (
    .adc_clk    (adc_clk           ),
    .rst_n_i    (rst_n_i           ),
    .raw_i      (adc_raw_i         ),
    .loop_i     (cfg_i.digital_loop), // loopback switch
    .loop_dat_i (lim_dat           ),
    .smp_o      (adc_smp_o         )
  );

  //////////////////////////////////////////////////////////////////////
  // dac side
  //////////////////////////////////////////////////////////////////////

  dac_limit u_dac_limit (
    .adc_clk  (adc_clk    ),
    .rst_n_i  (rst_n_i    ),
    .asg_i    (asg_i      ),
    .pid_i    (pid_i      ),
    .lim_a_i  (cfg_i.lim_a),
    .lim_b_i  (cfg_i.lim_b),
    .dat_o    (lim_dat    ),
    .railed_o (railed_o   ),
    .center_o (center_o   )
  );

  // output register, 2nd cycle after asg/pid
  dac_encode u_dac_encode (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .dat_i     (lim_dat  ),
    .dac_o     (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

endmodule

`default_nettype wire

// File: verification/afe_tb.sv
// testbench for the two channel fast analog data path
// directed tests of reset, adc decode, sum/saturation, limiter and loopback

`timescale 1ns/100ps
`default_nettype none

`include "afe_params.svh"

module afe_tb
  import afe_pkg::*;
();

  localparam int CLK_NS = 4;
  localparam int N_VEC  = 400;                          // vectors per test
  localparam int WD_NS  = 5 * N_VEC * CLK_NS + 2000;   // five tests plus margin

  logic       adc_clk = 1'b0;
  logic       rst_n_i;
  raw_pair_t  adc_raw_i;
  smp_pair_t  asg_i, pid_i;
  afe_cfg_t   cfg_i;
  smp_pair_t  adc_smp_o, center_o;
  rail_pair_t railed_o;
  dac_pair_t  dac_dat_o;
  logic       dac_rst_o;

  // stimulus vectors and the config mirrored as integers
  int asg_a[N_VEC], asg_b[N_VEC], pid_a[N_VEC], pid_b[N_VEC];
  int raw_a[N_VEC], raw_b[N_VEC];
  int max_a, min_a, max_b, min_b;
  bit loop_on;
  int seed_val;

  always #(CLK_NS / 2) adc_clk = ~adc_clk;

  afe_datapath_top uut (
    .adc_clk   (adc_clk  ),
    .rst_n_i   (rst_n_i  ),
    .adc_raw_i (adc_raw_i),
    .asg_i     (asg_i    ),
    .pid_i     (pid_i    ),
    .cfg_i     (cfg_i    ),
    .adc_smp_o (adc_smp_o),
    .center_o  (center_o ),
    .railed_o  (railed_o ),
    .dac_dat_o (dac_dat_o),
    .dac_rst_o (dac_rst_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // negative slope code, full scale down to zero maps 8191 .. -8192
  function automatic int adc_ref(input int raw);
    return 8191 - (raw >> `AFE_ADC_PAD);
  endfunction

  function automatic int dac_ref(input int s);
    return 8191 - s; // inverse of the adc mapping
  endfunction

  function automatic int sat_ref(input int s);
    if (s > 8191) return 8191;
    if (s < -8192) return -8192;
    return s;
  endfunction

  function automatic int lim_ref(input int s, input int mx, input int mn);
    int v;
    v = sat_ref(s);
    if (v > mx) return mx; // upper wins on crossed limits
    if (v < mn) return mn;
    return v;
  endfunction

  function automatic int rail_ref(input int s, input int mx, input int mn);
    int v;
    v = sat_ref(s);
    if (v > mx) return 2;
    if (v < mn) return 1;
    return 0;
  endfunction

  function automatic int mid_ref(input int mx, input int mn);
    return (mx + mn) >>> 1; // arithmetic shift floors
  endfunction

  function automatic int rand_in(input int lo, input int hi);
    return lo + int'($urandom_range(hi - lo, 0));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checking and streaming
  //////////////////////////////////////////////////////////////////////

  task automatic check_eq(input string what, input int idx, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("FAIL t=%0t %s, vector %0d: got %0d, expected %0d",
               $time, what, idx, got, exp);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // one cycle outputs for vector k
  task automatic check_stage1(input int k);
    int sa, sb;
    begin
      sa = asg_a[k] + pid_a[k];
      sb = asg_b[k] + pid_b[k];
      check_eq("adc_smp_o.ch_a", k, $signed(adc_smp_o.ch_a),
               loop_on ? lim_ref(sa, max_a, min_a) : adc_ref(raw_a[k]));
      check_eq("adc_smp_o.ch_b", k, $signed(adc_smp_o.ch_b),
               loop_on ? lim_ref(sb, max_b, min_b) : adc_ref(raw_b[k]));
      check_eq("railed_o.ch_a", k, railed_o.ch_a, rail_ref(sa, max_a, min_a));
      check_eq("railed_o.ch_b", k, railed_o.ch_b, rail_ref(sb, max_b, min_b));
      check_eq("center_o.ch_a", k, $signed(center_o.ch_a), mid_ref(max_a, min_a));
      check_eq("center_o.ch_b", k, $signed(center_o.ch_b), mid_ref(max_b, min_b));
    end
  endtask

  // two cycle dac words for vector k
  task automatic check_dac(input int k);
    check_eq("dac_dat_o.ch_a", k, dac_dat_o.ch_a,
             dac_ref(lim_ref(asg_a[k] + pid_a[k], max_a, min_a)));
    check_eq("dac_dat_o.ch_b", k, dac_dat_o.ch_b,
             dac_ref(lim_ref(asg_b[k] + pid_b[k], max_b, min_b)));
  endtask

  // new vector every edge, outputs checked at the falling edge
  task automatic stream_vectors(input int n);
    int i;
    for (i = 0; i < n + 2; i++)
    begin
      @(posedge adc_clk);
      if (i < n)
      begin
        asg_i.ch_a     <= sample_t'(asg_a[i]);
        asg_i.ch_b     <= sample_t'(asg_b[i]);
        pid_i.ch_a     <= sample_t'(pid_a[i]);
        pid_i.ch_b     <= sample_t'(pid_b[i]);
        adc_raw_i.ch_a <= raw_a[i][`AFE_ADC_W-1:0];
        adc_raw_i.ch_b <= raw_b[i][`AFE_ADC_W-1:0];
      end
      @(negedge adc_clk);
      if (i >= 1 && i <= n) check_stage1(i - 1);
      if (i >= 2) check_dac(i - 2);
    end
  endtask

  task automatic set_cfg(input bit lp, input int mxa, input int mna,
                         input int mxb, input int mnb);
    @(posedge adc_clk);
    cfg_i.digital_loop  <= lp;
    cfg_i.lim_a.lim_max <= sample_t'(mxa);
    cfg_i.lim_a.lim_min <= sample_t'(mna);
    cfg_i.lim_b.lim_max <= sample_t'(mxb);
    cfg_i.lim_b.lim_min <= sample_t'(mnb);
    loop_on = lp;
    max_a = mxa;
    min_a = mna;
    max_b = mxb;
    min_b = mnb;
    repeat (2) @(posedge adc_clk); // center register settles
  endtask

  // random asg/pid in [lo, hi], random raw words
  task automatic fill_vectors(input int lo, input int hi);
    int i;
    for (i = 0; i < N_VEC; i++)
    begin
      asg_a[i] = rand_in(lo, hi);
      asg_b[i] = rand_in(lo, hi);
      pid_a[i] = rand_in(lo, hi);
      pid_b[i] = rand_in(lo, hi);
      raw_a[i] = rand_in(0, 65535);
      raw_b[i] = rand_in(0, 65535);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int i;
    begin
      for (i = 0; i < 3; i++)
      begin
        @(posedge adc_clk);
        @(negedge adc_clk);
        check_eq("dac_rst_o in reset", i, dac_rst_o, 1);
        check_eq("dac_dat_o.ch_a in reset", i, dac_dat_o.ch_a, `AFE_DAC_IDLE);
        check_eq("dac_dat_o.ch_b in reset", i, dac_dat_o.ch_b, `AFE_DAC_IDLE);
        check_eq("adc_smp_o in reset", i, adc_smp_o, 0);
      end
      @(posedge adc_clk);
      rst_n_i <= 1'b1;
      @(negedge adc_clk);
      check_eq("dac_rst_o first edge after release", 0, dac_rst_o, 1);
      @(posedge adc_clk);
      @(negedge adc_clk);
      // lim_dat still holds its reset zero here
      check_eq("dac_rst_o after reset", 0, dac_rst_o, 0);
      check_eq("railed_o after reset", 0, railed_o, 0);
      check_eq("dac_dat_o.ch_a idle", 0, dac_dat_o.ch_a, `AFE_DAC_IDLE);
      check_eq("dac_dat_o.ch_b idle", 0, dac_dat_o.ch_b, `AFE_DAC_IDLE);
    end
  endtask

  task automatic test_adc_decode();
    set_cfg(1'b0, 8191, -8192, 8191, -8192);
    fill_vectors(0, 0); // dac side idle
    raw_a[0] = 16'h0000;
    raw_b[0] = 16'hFFFF;
    raw_a[1] = 16'hFFFF;
    raw_b[1] = 16'h0000;
    stream_vectors(N_VEC);
  endtask

  task automatic test_sum_sat();
    set_cfg(1'b0, 8191, -8192, 8191, -8192);
    fill_vectors(-8192, 8191);
    asg_a[0] = 8191; // over the top
    pid_a[0] = 8191;
    asg_b[0] = -8192; // under the bottom
    pid_b[0] = -8192;
    asg_a[1] = 5000;
    pid_a[1] = 4000;
    asg_b[1] = -5000;
    pid_b[1] = -4000;
    asg_a[2] = 8191;
    pid_a[2] = -8192;
    asg_b[2] = 4095; // exactly full scale
    pid_b[2] = 4096;
    stream_vectors(N_VEC);
  endtask

  task automatic test_limiter();
    int i;
    begin
      set_cfg(1'b0, 1000, -500, -100, -3001);
      fill_vectors(-4000, 4000);
      for (i = 0; i < 4; i++)
      begin
        pid_a[i] = 0;
        pid_b[i] = 0;
      end
      asg_a[0] = 1000; // on and just past each limit
      asg_a[1] = 1001;
      asg_a[2] = -501;
      asg_a[3] = -500;
      asg_b[0] = -100;
      asg_b[1] = -99;
      asg_b[2] = -3002;
      asg_b[3] = -3001;
      stream_vectors(N_VEC);
    end
  endtask

  task automatic test_loop();
    set_cfg(1'b1, 2000, -2000, 500, -6000);
    fill_vectors(-8192, 8191);
    stream_vectors(N_VEC / 2);
    set_cfg(1'b0, 2000, -2000, 500, -6000); // back to the adc path
    fill_vectors(-8192, 8191);
    stream_vectors(N_VEC / 2);
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    #(WD_NS);
    $display("timeout: tests did not finish within %0d ns", WD_NS);
    $display("Verification failed");
    $fatal(1);
  end

  initial
  begin
    seed_val = $urandom(32'h7229);
    rst_n_i   <= 1'b0;
    adc_raw_i <= '0;
    asg_i     <= '{14'sd1200, -14'sd900}; // nonzero sum through reset
    pid_i     <= '0;
    cfg_i     <= '{digital_loop: 1'b0, lim_a: '{14'sd8191, -14'sd8192},
                   lim_b: '{14'sd8191, -14'sd8192}};
    test_reset();
    test_adc_decode();
    test_sum_sat();
    test_limiter();
    test_loop();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
src/afe_pkg.sv
src/adc_decode.sv
src/dac_limit.sv
src/dac_encode.sv
src/afe_datapath_top.sv
verification/afe_tb.sv

// File: Bender.yml
package:
  name: afe_datapath

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/afe_pkg.sv
      - src/adc_decode.sv
      - src/dac_limit.sv
      - src/dac_encode.sv
      - src/afe_datapath_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verification/afe_tb.sv
